//--- src/conf_bus_pkg.sv
package conf_bus_pkg;

    // Bus widths
    localparam int CONF_ADDR_W = 32;
    localparam int CONF_DATA_W = 32;

    typedef logic [CONF_ADDR_W-1:0] conf_addr_t;
    typedef logic [CONF_DATA_W-1:0] conf_data_t;

    // Target picked by the top three address bits
    typedef enum logic [2:0] {
        REG_IMEM = 3'd0,    // 0x0000_0000, no target here
        REG_DSP  = 3'd1,    // 0x2000_0000
        REG_CAM  = 3'd2,    // 0x4000_0000
        REG_SCCB = 3'd3     // 0x6000_0000, no target here
    } region_e;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'd0,
        RESP_DECERR = 2'd3
    } resp_e;

    // Low address bits seen by a target
    localparam int REG_OFS_W = 8;

    // Display TX registers, byte spaced
    localparam logic [REG_OFS_W-1:0] DSP_CMD_OFS  = 8'h00;
    localparam logic [REG_OFS_W-1:0] DSP_CTRL_OFS = 8'h01;

    // Camera RX registers, word spaced
    localparam logic [REG_OFS_W-1:0] CAM_CTRL_OFS     = 8'h00;
    localparam logic [REG_OFS_W-1:0] CAM_PIX_CNT_OFS  = 8'h04;
    localparam logic [REG_OFS_W-1:0] CAM_DROP_CNT_OFS = 8'h08;

endpackage

//--- src/video_pkg.sv
package video_pkg;

    // Pin widths
    localparam int DVP_DATA_W = 8;
    localparam int DBI_DATA_W = 8;

    // RGB565, high byte arrives and leaves first
    typedef logic [15:0] pixel_t;

    typedef logic [15:0] count_t;

    // WRX phase lengths in system clock cycles
    localparam int WR_LOW_CYCLES  = 2;
    localparam int WR_HIGH_CYCLES = 2;

    // Wide enough for either phase count
    localparam int PHASE_W = $clog2(WR_LOW_CYCLES + WR_HIGH_CYCLES);

    typedef enum logic [1:0] {
        DBI_IDLE,   // csx high, bus released
        DBI_LOW,    // wrx low phase
        DBI_HIGH    // wrx high phase, display latches on the rising edge
    } dbi_state_e;

endpackage

//--- src/conf_decoder.sv
`timescale 1ns/1ns

module conf_decoder (
    input  logic                                sys_clk,
    input  logic                                rst_n_i,
    // Bus side
    input  logic                                conf_req_valid_i,
    output logic                                conf_req_ready_o,
    input  logic                                conf_write_i,
    input  conf_bus_pkg::conf_addr_t            conf_addr_i,
    input  conf_bus_pkg::conf_data_t            conf_wdata_i,
    output logic                                conf_rsp_valid_o,
    input  logic                                conf_rsp_ready_i,
    output conf_bus_pkg::conf_data_t            conf_rdata_o,
    output conf_bus_pkg::resp_e                 conf_resp_o,
    // Target side
    output logic                                dsp_sel_o,
    output logic                                cam_sel_o,
    output logic                                wr_o,
    output logic [conf_bus_pkg::REG_OFS_W-1:0]  reg_ofs_o,
    output conf_bus_pkg::conf_data_t            wdata_o,
    input  conf_bus_pkg::conf_data_t            dsp_rdata_i,
    input  logic                                dsp_ready_i,
    input  conf_bus_pkg::conf_data_t            cam_rdata_i
);
    import conf_bus_pkg::*;

    region_e    region;
    logic       tgt_ready;
    conf_data_t tgt_rdata;
    resp_e      tgt_resp;
    logic       accept;
    logic       rsp_valid_q;
    conf_data_t rdata_q;
    resp_e      resp_q;

    assign region = region_e'(conf_addr_i[CONF_ADDR_W-1 -: $bits(region_e)]);

    always_comb begin
        tgt_ready = 1'b1;
        tgt_rdata = '0;
        tgt_resp  = RESP_DECERR;
        case (region)
            REG_DSP: begin
                tgt_ready = dsp_ready_i;
                tgt_rdata = dsp_rdata_i;
                tgt_resp  = RESP_OKAY;
            end
            REG_CAM: begin
                tgt_rdata = cam_rdata_i;    // Camera never stalls
                tgt_resp  = RESP_OKAY;
            end
            REG_IMEM, REG_SCCB: ;
            default: ;
        endcase
    end

    // One request in flight at a time
    assign conf_req_ready_o = ~rsp_valid_q & tgt_ready;
    assign accept           = conf_req_valid_i & conf_req_ready_o;

    assign dsp_sel_o = accept & (region == REG_DSP);
    assign cam_sel_o = accept & (region == REG_CAM);
    assign wr_o      = conf_write_i;
    assign reg_ofs_o = conf_addr_i[REG_OFS_W-1:0];
    assign wdata_o   = conf_wdata_i;

    always_ff @(posedge sys_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rsp_valid_q <= 1'b0;
        end else if (accept) begin
            rsp_valid_q <= 1'b1;
        end else if (conf_rsp_ready_i) begin
            rsp_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (accept) begin
            rdata_q <= conf_write_i ? '0 : tgt_rdata;
            resp_q  <= tgt_resp;
        end
    end

    assign conf_rsp_valid_o = rsp_valid_q;
    assign conf_rdata_o     = rdata_q;
    assign conf_resp_o      = resp_q;

    // Master keeps a stalled request unchanged
    a_req_stable: assert property (@(posedge sys_clk) disable iff (!rst_n_i)
        conf_req_valid_i && !conf_req_ready_o |=>
            conf_req_valid_i && $stable(conf_write_i) && $stable(conf_addr_i)
            && $stable(conf_wdata_i));

    a_rsp_hold: assert property (@(posedge sys_clk) disable iff (!rst_n_i)
        conf_rsp_valid_o && !conf_rsp_ready_i |=>
            conf_rsp_valid_o && $stable(conf_rdata_o) && $stable(conf_resp_o));

endmodule

//--- src/dvp_rx_capture.sv
`timescale 1ns/1ns

module dvp_rx_capture (
    input  logic                                sys_clk,
    input  logic                                rst_n_i,
    // DVP pins
    input  logic [video_pkg::DVP_DATA_W-1:0]    dvp_d_i,
    input  logic                                dvp_href_i,
    input  logic                                dvp_vsync_i,
    input  logic                                dvp_pclk_i,
    // Register access
    input  logic                                sel_i,
    input  logic                                wr_i,
    input  logic [conf_bus_pkg::REG_OFS_W-1:0]  reg_ofs_i,
    input  conf_bus_pkg::conf_data_t            wdata_i,
    output conf_bus_pkg::conf_data_t            rdata_o,
    // Pixel stream
    output logic                                pix_valid_o,
    input  logic                                pix_ready_i,
    output video_pkg::pixel_t                   pix_data_o
);
    import conf_bus_pkg::*;
    import video_pkg::*;

    logic [2:0]             pclk_sync;  // Two sync stages plus one for edge detect
    logic [1:0]             href_sync;
    logic [1:0]             vsync_sync;
    logic [DVP_DATA_W-1:0]  d_s1;
    logic [DVP_DATA_W-1:0]  d_s2;
    logic                   pclk_rise;
    logic                   byte_take;
    logic                   pix_done;
    logic                   pix_load;
    logic                   pix_drop;
    logic                   ctrl_wr;
    logic                   cap_en_q;
    logic                   byte_phase_q;
    logic [DVP_DATA_W-1:0]  hi_byte_q;
    pixel_t                 pix_q;
    logic                   pix_valid_q;
    count_t                 pix_cnt_q;
    count_t                 drop_cnt_q;

    always_ff @(posedge sys_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pclk_sync  <= '0;
            href_sync  <= '0;
            vsync_sync <= '0;
        end else begin
            pclk_sync  <= {pclk_sync[1:0], dvp_pclk_i};
            href_sync  <= {href_sync[0], dvp_href_i};
            vsync_sync <= {vsync_sync[0], dvp_vsync_i};
        end
    end

    always_ff @(posedge sys_clk) begin
        d_s1 <= dvp_d_i;
        d_s2 <= d_s1;
    end

    assign pclk_rise = pclk_sync[1] & ~pclk_sync[2];
    assign byte_take = pclk_rise & href_sync[1] & ~vsync_sync[1] & cap_en_q;
    assign pix_done  = byte_take & byte_phase_q;
    // A held pixel leaving this cycle frees the slot
    assign pix_load  = pix_done & (~pix_valid_q | pix_ready_i);
    assign pix_drop  = pix_done & pix_valid_q & ~pix_ready_i;
    assign ctrl_wr   = sel_i & wr_i & (reg_ofs_i == CAM_CTRL_OFS);

    // CTRL bit 0 enables capture, writing bit 1 clears both counters
    always_ff @(posedge sys_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cap_en_q     <= 1'b0;
            byte_phase_q <= 1'b0;
            pix_valid_q  <= 1'b0;
            pix_cnt_q    <= '0;
            drop_cnt_q   <= '0;
        end else begin
            if (ctrl_wr) cap_en_q <= wdata_i[0];

            if (vsync_sync[1] || !cap_en_q) begin
                byte_phase_q <= 1'b0;   // Realign at frame start
            end else if (byte_take) begin
                byte_phase_q <= ~byte_phase_q;
            end

            if (pix_load) begin
                pix_valid_q <= 1'b1;
            end else if (pix_ready_i) begin
                pix_valid_q <= 1'b0;
            end

            if (ctrl_wr && wdata_i[1]) begin
                pix_cnt_q  <= '0;
                drop_cnt_q <= '0;
            end else begin
                if (pix_load) pix_cnt_q <= pix_cnt_q + 1'b1;
                if (pix_drop) drop_cnt_q <= drop_cnt_q + 1'b1;
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (byte_take && !byte_phase_q) hi_byte_q <= d_s2;
        if (pix_load) pix_q <= {hi_byte_q, d_s2};
    end

    always_comb begin
        case (reg_ofs_i)
            CAM_CTRL_OFS:     rdata_o = conf_data_t'(cap_en_q);
            CAM_PIX_CNT_OFS:  rdata_o = conf_data_t'(pix_cnt_q);
            CAM_DROP_CNT_OFS: rdata_o = conf_data_t'(drop_cnt_q);
            default:          rdata_o = '0;
        endcase
    end

    assign pix_valid_o = pix_valid_q;
    assign pix_data_o  = pix_q;

    a_pix_hold: assert property (@(posedge sys_clk) disable iff (!rst_n_i)
        pix_valid_o && !pix_ready_i |=> pix_valid_o && $stable(pix_data_o));

endmodule

//--- src/dbi_tx_engine.sv
`timescale 1ns/1ns

module dbi_tx_engine (
    input  logic                                sys_clk,
    input  logic                                rst_n_i,
    // Register access
    input  logic                                sel_i,
    input  logic                                wr_i,
    input  logic [conf_bus_pkg::REG_OFS_W-1:0]  reg_ofs_i,
    input  conf_bus_pkg::conf_data_t            wdata_i,
    output conf_bus_pkg::conf_data_t            rdata_o,
    output logic                                ready_o,
    // Pixel stream
    input  logic                                pix_valid_i,
    output logic                                pix_ready_o,
    input  video_pkg::pixel_t                   pix_data_i,
    // DBI pins
    output logic                                dbi_dcx_o,
    output logic                                dbi_csx_o,
    output logic                                dbi_resx_o,
    output logic                                dbi_rdx_o,
    output logic                                dbi_wrx_o,
    output logic [video_pkg::DBI_DATA_W-1:0]    dbi_d_o
);
    import conf_bus_pkg::*;
    import video_pkg::*;

    dbi_state_e             state_q;
    logic [PHASE_W-1:0]     phase_q;
    logic                   more_q;     // Low byte of a pixel still to go
    logic                   dcx_q;
    logic [1:0]             ctrl_q;     // [0] resx, [1] stream enable
    logic [DBI_DATA_W-1:0]  byte_q;
    logic [DBI_DATA_W-1:0]  lo_byte_q;
    logic                   idle;
    logic                   cmd_wr;
    logic                   ctrl_wr;
    logic                   pix_take;
    logic                   phase_end;

    assign idle      = (state_q == DBI_IDLE);
    assign cmd_wr    = sel_i & wr_i & (reg_ofs_i == DSP_CMD_OFS);
    assign ctrl_wr   = sel_i & wr_i & (reg_ofs_i == DSP_CTRL_OFS);
    assign phase_end = (phase_q == '0);

    // Command writes stall the bus until the current byte train ends
    assign ready_o     = idle | ~(wr_i & (reg_ofs_i == DSP_CMD_OFS));
    assign pix_ready_o = idle & ctrl_q[1] & ~cmd_wr;   // Commands first
    assign pix_take    = pix_valid_i & pix_ready_o;

    always_ff @(posedge sys_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= DBI_IDLE;
            phase_q <= '0;
            more_q  <= 1'b0;
            dcx_q   <= 1'b1;
            ctrl_q  <= '0;
        end else begin
            if (ctrl_wr) ctrl_q <= wdata_i[1:0];
            case (state_q)
                DBI_IDLE: begin
                    if (cmd_wr || pix_take) begin
                        state_q <= DBI_LOW;
                        phase_q <= PHASE_W'(WR_LOW_CYCLES - 1);
                        dcx_q   <= ~cmd_wr;
                        more_q  <= ~cmd_wr;
                    end
                end
                DBI_LOW: begin
                    if (phase_end) begin
                        state_q <= DBI_HIGH;
                        phase_q <= PHASE_W'(WR_HIGH_CYCLES - 1);
                    end else begin
                        phase_q <= phase_q - 1'b1;
                    end
                end
                DBI_HIGH: begin
                    if (!phase_end) begin
                        phase_q <= phase_q - 1'b1;
                    end else if (more_q) begin
                        state_q <= DBI_LOW;
                        phase_q <= PHASE_W'(WR_LOW_CYCLES - 1);
                        more_q  <= 1'b0;
                    end else begin
                        state_q <= DBI_IDLE;
                    end
                end
                default: state_q <= DBI_IDLE;
            endcase
        end
    end

    // Byte on the pins changes only as wrx falls
    always_ff @(posedge sys_clk) begin
        if (cmd_wr && idle) begin
            byte_q <= wdata_i[DBI_DATA_W-1:0];
        end else if (pix_take) begin
            byte_q    <= pix_data_i[$bits(pixel_t)-1 -: DBI_DATA_W];
            lo_byte_q <= pix_data_i[DBI_DATA_W-1:0];
        end else if (state_q == DBI_HIGH && phase_end && more_q) begin
            byte_q <= lo_byte_q;
        end
    end

    assign rdata_o = (reg_ofs_i == DSP_CTRL_OFS) ? conf_data_t'(ctrl_q) : '0;

    assign dbi_csx_o  = idle;
    assign dbi_wrx_o  = (state_q != DBI_LOW);
    assign dbi_dcx_o  = dcx_q;
    assign dbi_d_o    = byte_q;
    assign dbi_resx_o = ctrl_q[0];
    assign dbi_rdx_o  = 1'b1;   // Write only

    // Display samples d and dcx as wrx rises
    a_byte_hold: assert property (@(posedge sys_clk) disable iff (!rst_n_i)
        !dbi_wrx_o |=> $stable(dbi_d_o) && $stable(dbi_dcx_o));

endmodule

//--- src/dcasic.sv
`timescale 1ns/1ns

module dcasic (
    input  logic                                sys_clk,
    input  logic                                rst_n_i,
    // Configuration bus
    input  logic                                conf_req_valid_i,
    output logic                                conf_req_ready_o,
    input  logic                                conf_write_i,
    input  conf_bus_pkg::conf_addr_t            conf_addr_i,
    input  conf_bus_pkg::conf_data_t            conf_wdata_i,
    output logic                                conf_rsp_valid_o,
    input  logic                                conf_rsp_ready_i,
    output conf_bus_pkg::conf_data_t            conf_rdata_o,
    output conf_bus_pkg::resp_e                 conf_resp_o,
    // Camera RX
    input  logic [video_pkg::DVP_DATA_W-1:0]    dvp_d_i,
    input  logic                                dvp_href_i,
    input  logic                                dvp_vsync_i,
    input  logic                                dvp_pclk_i,
    // Display TX
    output logic                                dbi_dcx_o,
    output logic                                dbi_csx_o,
    output logic                                dbi_resx_o,
    output logic                                dbi_rdx_o,
    output logic                                dbi_wrx_o,
    output logic [video_pkg::DBI_DATA_W-1:0]    dbi_d_o
);
    import conf_bus_pkg::*;
    import video_pkg::*;

    logic                   dsp_sel;
    logic                   cam_sel;
    logic                   reg_wr;
    logic [REG_OFS_W-1:0]   reg_ofs;
    conf_data_t             reg_wdata;
    conf_data_t             dsp_rdata;
    logic                   dsp_ready;
    conf_data_t             cam_rdata;
    logic                   pix_valid;
    logic                   pix_ready;
    pixel_t                 pix_data;

    conf_decoder dec (
        .sys_clk            (sys_clk),
        .rst_n_i            (rst_n_i),
        .conf_req_valid_i   (conf_req_valid_i),
        .conf_req_ready_o   (conf_req_ready_o),
        .conf_write_i       (conf_write_i),
        .conf_addr_i        (conf_addr_i),
        .conf_wdata_i       (conf_wdata_i),
        .conf_rsp_valid_o   (conf_rsp_valid_o),
        .conf_rsp_ready_i   (conf_rsp_ready_i),
        .conf_rdata_o       (conf_rdata_o),
        .conf_resp_o        (conf_resp_o),
        .dsp_sel_o          (dsp_sel),
        .cam_sel_o          (cam_sel),
        .wr_o               (reg_wr),
        .reg_ofs_o          (reg_ofs),
        .wdata_o            (reg_wdata),
        .dsp_rdata_i        (dsp_rdata),
        .dsp_ready_i        (dsp_ready),
        .cam_rdata_i        (cam_rdata)
    );

    // Camera RX controller
    dvp_rx_capture crc (
        .sys_clk            (sys_clk),
        .rst_n_i            (rst_n_i),
        .dvp_d_i            (dvp_d_i),
        .dvp_href_i         (dvp_href_i),
        .dvp_vsync_i        (dvp_vsync_i),
        .dvp_pclk_i         (dvp_pclk_i),
        .sel_i              (cam_sel),
        .wr_i               (reg_wr),
        .reg_ofs_i          (reg_ofs),
        .wdata_i            (reg_wdata),
        .rdata_o            (cam_rdata),
        .pix_valid_o        (pix_valid),
        .pix_ready_i        (pix_ready),
        .pix_data_o         (pix_data)
    );

    // Display TX controller
    dbi_tx_engine dtc (
        .sys_clk            (sys_clk),
        .rst_n_i            (rst_n_i),
        .sel_i              (dsp_sel),
        .wr_i               (reg_wr),
        .reg_ofs_i          (reg_ofs),
        .wdata_i            (reg_wdata),
        .rdata_o            (dsp_rdata),
        .ready_o            (dsp_ready),
        .pix_valid_i        (pix_valid),
        .pix_ready_o        (pix_ready),
        .pix_data_i         (pix_data),
        .dbi_dcx_o          (dbi_dcx_o),
        .dbi_csx_o          (dbi_csx_o),
        .dbi_resx_o         (dbi_resx_o),
        .dbi_rdx_o          (dbi_rdx_o),
        .dbi_wrx_o          (dbi_wrx_o),
        .dbi_d_o            (dbi_d_o)
    );

endmodule

//--- bench/tb_dcasic.sv
`timescale 1ns/1ns

module tb_dcasic;
    import conf_bus_pkg::*;
    import video_pkg::*;

    localparam int WAIT_LIMIT = 200;    // Cycles before a wait gives up
    localparam int NUM_PIX    = 6;
    localparam int NUM_CMD    = 4;

    typedef struct packed {
        logic                  dcx;
        logic [DBI_DATA_W-1:0] d;
    } dbi_byte_t;

    logic                   sys_clk;
    logic                   rst_n_i;
    logic                   conf_req_valid_i;
    logic                   conf_req_ready_o;
    logic                   conf_write_i;
    conf_addr_t             conf_addr_i;
    conf_data_t             conf_wdata_i;
    logic                   conf_rsp_valid_o;
    logic                   conf_rsp_ready_i;
    conf_data_t             conf_rdata_o;
    resp_e                  conf_resp_o;
    logic [DVP_DATA_W-1:0]  dvp_d_i;
    logic                   dvp_href_i;
    logic                   dvp_vsync_i;
    logic                   dvp_pclk_i;
    logic                   dbi_dcx_o;
    logic                   dbi_csx_o;
    logic                   dbi_resx_o;
    logic                   dbi_rdx_o;
    logic                   dbi_wrx_o;
    logic [DBI_DATA_W-1:0]  dbi_d_o;

    dbi_byte_t   dbi_log[$];
    pixel_t      sent_pix[$];
    logic [31:0] lcg_state;
    int          checks;
    int          errors;
    int          test_errors;

    dcasic i_dcasic (.*);

    initial begin
        sys_clk = 1'b0;
        forever #20 sys_clk = ~sys_clk;
    end

    // Display latches on the rising edge of wrx
    always @(posedge dbi_wrx_o) dbi_log.push_back({dbi_dcx_o, dbi_d_o});

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic conf_addr_t reg_addr(input logic [2:0] region,
                                            input logic [REG_OFS_W-1:0] ofs);
        return {region, {(CONF_ADDR_W - $bits(region_e) - REG_OFS_W){1'b0}}, ofs};
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $finish;
    endtask

    task automatic check_data(input conf_data_t got, input conf_data_t exp, input string what);
        checks++;
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
            test_errors++;
        end
    endtask

    task automatic check_resp(input resp_e got, input resp_e exp, input string what);
        checks++;
        if (got !== exp) begin
            $display("Fail at %0t ns: %s response %s (%0d), expected %s",
                     $time, what, got.name(), got, exp.name());
            test_errors++;
        end
    endtask

    task automatic check_dbi(input dbi_byte_t got, input dbi_byte_t exp, input string what);
        checks++;
        if (got !== exp) begin
            $display("Fail at %0t ns: %s byte 0x%02h dcx %0b, expected 0x%02h dcx %0b",
                     $time, what, got.d, got.dcx, exp.d, exp.dcx);
            test_errors++;
        end
    endtask

    task automatic check_pin(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            $display("Fail at %0t ns: pin %s is %b, expected %b", $time, what, got, exp);
            test_errors++;
        end
    endtask

    task automatic bus_access(input logic wr, input conf_addr_t addr, input conf_data_t wdata,
                              output conf_data_t rdata, output resp_e resp);
        int cycles;
        @(posedge sys_clk);
        conf_req_valid_i <= 1'b1;
        conf_write_i     <= wr;
        conf_addr_i      <= addr;
        conf_wdata_i     <= wdata;
        conf_rsp_ready_i <= 1'b0;
        cycles = 0;
        do begin
            @(negedge sys_clk);
            cycles++;
        end while (!conf_req_ready_o && cycles < WAIT_LIMIT);
        if (!conf_req_ready_o) abort_run($sformatf("Request to 0x%08h never accepted", addr));
        @(posedge sys_clk);
        conf_req_valid_i <= 1'b0;
        cycles = 0;
        do begin
            @(negedge sys_clk);
            cycles++;
        end while (!conf_rsp_valid_o && cycles < WAIT_LIMIT);
        if (!conf_rsp_valid_o) abort_run($sformatf("No response for 0x%08h", addr));
        rdata = conf_rdata_o;
        resp  = conf_resp_o;
        @(posedge sys_clk);
        conf_rsp_ready_i <= 1'b1;
        @(negedge sys_clk);
        check_pin(conf_rsp_valid_o, 1'b1, "conf_rsp_valid before ready");  // Held until taken
        @(negedge sys_clk);
        check_pin(conf_rsp_valid_o, 1'b0, "conf_rsp_valid after ready");
    endtask

    task automatic write_reg(input conf_addr_t addr, input conf_data_t wdata);
        conf_data_t rdata;
        resp_e      resp;
        bus_access(1'b1, addr, wdata, rdata, resp);
        check_resp(resp, RESP_OKAY, "write");
        check_data(rdata, '0, "write rdata");
    endtask

    task automatic read_reg(input conf_addr_t addr, input conf_data_t exp, input string what);
        conf_data_t rdata;
        resp_e      resp;
        bus_access(1'b0, addr, '0, rdata, resp);
        check_resp(resp, RESP_OKAY, what);
        check_data(rdata, exp, what);
    endtask

    // One byte per 16 system cycles, pclk rises mid byte
    task automatic drive_byte(input logic [DVP_DATA_W-1:0] b);
        @(posedge sys_clk);
        dvp_d_i    <= b;
        dvp_pclk_i <= 1'b0;
        repeat (8) @(posedge sys_clk);
        dvp_pclk_i <= 1'b1;
        repeat (7) @(posedge sys_clk);
    endtask

    task automatic drive_line(input int n);
        logic [31:0] rnd;
        sent_pix.delete();
        @(posedge sys_clk);
        dvp_href_i <= 1'b1;
        for (int i = 0; i < n; i++) begin
            rnd = lcg_next();
            sent_pix.push_back(rnd[23:8]);
            drive_byte(rnd[23:16]);     // High byte first
            drive_byte(rnd[15:8]);
        end
        @(posedge sys_clk);
        dvp_href_i <= 1'b0;
        repeat (8) @(posedge sys_clk);
    endtask

    task automatic wait_dbi_count(input int n);
        int cycles;
        cycles = 0;
        while (dbi_log.size() < n && cycles < WAIT_LIMIT) begin
            @(negedge sys_clk);
            cycles++;
        end
        if (dbi_log.size() < n)
            abort_run($sformatf("Only %0d DBI bytes seen, %0d expected", dbi_log.size(), n));
    endtask

    task automatic end_test(input string name);
        $display("%s: %0d errors", name, test_errors);
        errors += test_errors;
        test_errors = 0;
    endtask

    task automatic test_reset_state();
        @(negedge sys_clk);
        check_pin(dbi_csx_o, 1'b1, "csx");
        check_pin(dbi_wrx_o, 1'b1, "wrx");
        check_pin(dbi_rdx_o, 1'b1, "rdx");
        check_pin(dbi_dcx_o, 1'b1, "dcx");
        check_pin(dbi_resx_o, 1'b0, "resx");
        check_pin(conf_req_ready_o, 1'b1, "conf_req_ready");
        check_pin(conf_rsp_valid_o, 1'b0, "conf_rsp_valid");
        read_reg(reg_addr(REG_CAM, CAM_PIX_CNT_OFS), '0, "pixel count");
        read_reg(reg_addr(REG_CAM, CAM_DROP_CNT_OFS), '0, "drop count");
        end_test("reset state");
    endtask

    task automatic test_register_access();
        logic [2:0] dead_regions[3] = '{3'd0, 3'd3, 3'd5};
        conf_data_t rdata;
        resp_e      resp;
        write_reg(reg_addr(REG_DSP, DSP_CTRL_OFS), 32'h3);
        read_reg(reg_addr(REG_DSP, DSP_CTRL_OFS), 32'h3, "display ctrl");
        check_pin(dbi_resx_o, 1'b1, "resx");
        write_reg(reg_addr(REG_DSP, DSP_CTRL_OFS), 32'h5);   // Only bits 1:0 exist
        read_reg(reg_addr(REG_DSP, DSP_CTRL_OFS), 32'h1, "display ctrl");
        write_reg(reg_addr(REG_CAM, CAM_CTRL_OFS), 32'h1);
        read_reg(reg_addr(REG_CAM, CAM_CTRL_OFS), 32'h1, "camera ctrl");
        write_reg(reg_addr(REG_CAM, CAM_CTRL_OFS), 32'h0);
        read_reg(reg_addr(REG_CAM, CAM_CTRL_OFS), 32'h0, "camera ctrl");
        read_reg(reg_addr(REG_DSP, 8'h10), '0, "unused display offset");
        foreach (dead_regions[i]) begin
            bus_access(1'b0, reg_addr(dead_regions[i], 8'h04), '0, rdata, resp);
            check_resp(resp, RESP_DECERR, $sformatf("read of region %0d", dead_regions[i]));
            check_data(rdata, '0, $sformatf("read of region %0d", dead_regions[i]));
            bus_access(1'b1, reg_addr(dead_regions[i], 8'h00), 32'hdead_beef, rdata, resp);
            check_resp(resp, RESP_DECERR, $sformatf("write to region %0d", dead_regions[i]));
            check_data(rdata, '0, $sformatf("write to region %0d", dead_regions[i]));
        end
        end_test("register access and decode");
    endtask

    task automatic test_commands();
        dbi_byte_t   exp_q[$];
        logic [31:0] rnd;
        dbi_log.delete();
        for (int i = 0; i < NUM_CMD; i++) begin
            rnd = lcg_next();
            exp_q.push_back({1'b0, rnd[23:16]});
            write_reg(reg_addr(REG_DSP, DSP_CMD_OFS), conf_data_t'(rnd[23:16]));
        end
        wait_dbi_count(NUM_CMD);
        check_data(conf_data_t'(dbi_log.size()), NUM_CMD, "command byte count");
        foreach (exp_q[i]) check_dbi(dbi_log[i], exp_q[i], $sformatf("command %0d", i));
        end_test("commands");
    endtask

    task automatic test_pixel_stream();
        write_reg(reg_addr(REG_DSP, DSP_CTRL_OFS), 32'h3);
        write_reg(reg_addr(REG_CAM, CAM_CTRL_OFS), 32'h3);   // Enable and clear counters
        dbi_log.delete();
        drive_line(NUM_PIX);
        wait_dbi_count(2 * NUM_PIX);
        check_data(conf_data_t'(dbi_log.size()), 2 * NUM_PIX, "pixel byte count");
        foreach (sent_pix[i]) begin
            check_dbi(dbi_log[2*i], {1'b1, sent_pix[i][15:8]}, $sformatf("pixel %0d high", i));
            check_dbi(dbi_log[2*i+1], {1'b1, sent_pix[i][7:0]}, $sformatf("pixel %0d low", i));
        end
        read_reg(reg_addr(REG_CAM, CAM_PIX_CNT_OFS), NUM_PIX, "pixel count");
        read_reg(reg_addr(REG_CAM, CAM_DROP_CNT_OFS), '0, "drop count");
        end_test("pixel streaming");
    endtask

    task automatic test_back_pressure();
        write_reg(reg_addr(REG_DSP, DSP_CTRL_OFS), 32'h1);
        write_reg(reg_addr(REG_CAM, CAM_CTRL_OFS), 32'h3);
        dbi_log.delete();
        drive_line(NUM_PIX);
        repeat (16) @(posedge sys_clk);
        check_data(conf_data_t'(dbi_log.size()), '0, "bytes while stream is off");
        // First pixel is held, the rest are discarded
        read_reg(reg_addr(REG_CAM, CAM_PIX_CNT_OFS), 32'd1, "pixel count");
        read_reg(reg_addr(REG_CAM, CAM_DROP_CNT_OFS), NUM_PIX - 1, "drop count");
        write_reg(reg_addr(REG_DSP, DSP_CTRL_OFS), 32'h3);
        wait_dbi_count(2);
        check_dbi(dbi_log[0], {1'b1, sent_pix[0][15:8]}, "held pixel high");
        check_dbi(dbi_log[1], {1'b1, sent_pix[0][7:0]}, "held pixel low");
        end_test("back-pressure");
    endtask

    task automatic test_capture_off();
        write_reg(reg_addr(REG_CAM, CAM_CTRL_OFS), 32'h2);   // Clear counters, capture off
        repeat (16) @(posedge sys_clk);
        dbi_log.delete();
        drive_line(3);
        repeat (16) @(posedge sys_clk);
        check_data(conf_data_t'(dbi_log.size()), '0, "bytes with capture off");
        read_reg(reg_addr(REG_CAM, CAM_PIX_CNT_OFS), '0, "pixel count");
        read_reg(reg_addr(REG_CAM, CAM_DROP_CNT_OFS), '0, "drop count");
        end_test("capture disabled");
    endtask

    initial begin
        rst_n_i          = 1'b0;
        conf_req_valid_i = 1'b0;
        conf_write_i     = 1'b0;
        conf_addr_i      = '0;
        conf_wdata_i     = '0;
        conf_rsp_ready_i = 1'b1;
        dvp_d_i          = '0;
        dvp_href_i       = 1'b0;
        dvp_vsync_i      = 1'b0;
        dvp_pclk_i       = 1'b0;
        lcg_state        = 32'h8315;
        checks           = 0;
        errors           = 0;
        test_errors      = 0;
        repeat (16) @(posedge sys_clk);
        rst_n_i <= 1'b1;
        dbi_log.delete();   // Drop the edge seen as reset releases wrx

        test_reset_state();
        test_register_access();
        test_commands();
        test_pixel_stream();
        test_back_pressure();
        test_capture_off();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- sources.f
src/conf_bus_pkg.sv
src/video_pkg.sv
src/conf_decoder.sv
src/dvp_rx_capture.sv
src/dbi_tx_engine.sv
src/dcasic.sv
bench/tb_dcasic.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal -f sources.f \
        --top-module tb_dcasic -o sim_tb_dcasic; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/sim_tb_dcasic > "$LOG" 2>&1; then
    cat "$LOG"
    echo "Simulation exited with an error"
    exit 1
fi
cat "$LOG"

if grep -q "TEST RESULT: FAIL" "$LOG"; then
    exit 1
fi
exit 0
